/* common/msx_pkg.sv */
package msx_pkg;

    localparam int addr_w         = 27;     // Flat SDRAM address space
    localparam int layout_entries = 64;     // Slot x subslot x page
    localparam int region_entries = 16;
    localparam int kind_w         = 2;
    localparam int ref_w          = 4;      // Region reference
    localparam int blocks_w       = 8;      // Region size in 16K blocks
    localparam int page_w         = 14;     // 16K page / block
    localparam int bank8_w        = 13;     // 8K bank window of ascii8

    // Two cartridge bank sets, picked by bit 0 of the region reference
    localparam int cart_w   = 1;
    localparam int cart_bit = 0;

    // Mapper kinds
    localparam logic [kind_w-1:0] kind_none    = 2'd0;
    localparam logic [kind_w-1:0] kind_linear  = 2'd1;  // Plain RAM or ROM
    localparam logic [kind_w-1:0] kind_ascii8  = 2'd2;
    localparam logic [kind_w-1:0] kind_ascii16 = 2'd3;

    // Layout word, kind in 5:4 and region reference in 3:0
    localparam int layout_w        = 6;
    localparam int layout_kind_lsb = 4;
    localparam int layout_ref_lsb  = 0;

    // Region word, base 26:0, blocks 34:27, read-only 35
    localparam int region_w          = 36;
    localparam int region_base_lsb   = 0;
    localparam int region_blocks_lsb = 27;
    localparam int region_ro_bit     = 35;

    localparam logic [15:0] expander_addr = 16'hFFFF;  // Secondary slot register
    localparam logic [7:0]  unmapped_data = 8'hFF;

    // Request sequencer states
    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_decide = 2'd1;  // Captured, lookups settle
    localparam logic [1:0] st_mem    = 2'd2;  // Waiting for mem_ready
    localparam logic [1:0] st_done   = 2'd3;  // cpu_ready cycle

endpackage

/* slots/slot_expander.sv */
module slot_expander (
    input  logic        clk_sdram,
    input  logic        rst_n,
    input  logic [1:0]  active_slot,
    input  logic [3:0]  expander_en,   // One bit per primary slot
    input  logic [15:0] req_addr,
    input  logic        req_wr,
    input  logic [7:0]  req_wdata,
    input  logic        req_take,
    output logic        hit,
    output logic [1:0]  subslot,
    output logic [7:0]  rdata
);

    logic [7:0] sub_reg [4];  // Secondary slot register per primary slot
    logic [7:0] cur_reg;

    assign cur_reg = sub_reg[active_slot];

    // FFFF belongs to the expander only on an expanded slot
    assign hit = expander_en[active_slot] && (req_addr == msx_pkg::expander_addr);

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                sub_reg[i] <= 8'h00;
            end
        end else if (req_take && hit && req_wr) begin
            sub_reg[active_slot] <= req_wdata;
        end
    end

    // Two bits per 16K page, page taken from address 15:14
    always_comb begin
        if (!expander_en[active_slot]) begin
            subslot = 2'd0;                          // Flat slot, subslot 0
        end else begin
            subslot = cur_reg[2*req_addr[15:14] +: 2];
        end
    end

    assign rdata = ~cur_reg;  // Readback is inverted on MSX

endmodule

/* slots/slot_layout_table.sv */
module slot_layout_table (
    input  logic                         clk_sdram,
    input  logic                         rst_n,
    input  logic                         cfg_we,
    input  logic                         cfg_sel,        // 0 layout, 1 region
    input  logic [5:0]                   cfg_index,
    input  logic [msx_pkg::region_w-1:0] cfg_data,
    input  logic [5:0]                   layout_id,      // {slot, subslot, page}
    output logic [msx_pkg::kind_w-1:0]   kind,
    output logic [msx_pkg::ref_w-1:0]    region_ref,
    output logic [msx_pkg::addr_w-1:0]   region_base,
    output logic [msx_pkg::blocks_w-1:0] region_blocks,
    output logic                         region_ro
);

    logic [msx_pkg::layout_w-1:0]       layout_mem [msx_pkg::layout_entries];
    logic [msx_pkg::layout_entries-1:0] layout_set;  // Entry has been loaded
    logic [msx_pkg::region_w-1:0]       region_mem [msx_pkg::region_entries];
    logic [msx_pkg::layout_w-1:0]       entry;
    logic [msx_pkg::region_w-1:0]       region;

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            layout_set <= '0;
        end else if (cfg_we && !cfg_sel) begin
            layout_set[cfg_index] <= 1'b1;
        end
    end

    // Table storage
    always_ff @(posedge clk_sdram) begin
        if (cfg_we && !cfg_sel) begin
            layout_mem[cfg_index] <= cfg_data[msx_pkg::layout_w-1:0];
        end
        if (cfg_we && cfg_sel) begin
            region_mem[cfg_index[msx_pkg::ref_w-1:0]] <= cfg_data;  // 16 regions
        end
    end

    assign entry = layout_mem[layout_id];

    // Unloaded entries decode as unmapped
    always_comb begin
        if (layout_set[layout_id]) begin
            kind       = entry[msx_pkg::layout_kind_lsb +: msx_pkg::kind_w];
            region_ref = entry[msx_pkg::layout_ref_lsb +: msx_pkg::ref_w];
        end else begin
            kind       = msx_pkg::kind_none;
            region_ref = '0;
        end
    end

    // Second level, region referenced by the entry
    assign region        = region_mem[region_ref];
    assign region_base   = region[msx_pkg::region_base_lsb +: msx_pkg::addr_w];
    assign region_blocks = region[msx_pkg::region_blocks_lsb +: msx_pkg::blocks_w];
    assign region_ro     = region[msx_pkg::region_ro_bit];

endmodule

/* mappers/mapper_bank.sv */
module mapper_bank (
    input  logic                       clk_sdram,
    input  logic                       rst_n,
    input  logic [msx_pkg::kind_w-1:0] kind,
    input  logic [msx_pkg::cart_w-1:0] cart,
    input  logic [15:0]                req_addr,
    input  logic                       req_wr,
    input  logic [7:0]                 req_wdata,
    input  logic                       req_take,
    output logic                       reg_hit,    // Bank register write
    output logic [msx_pkg::addr_w-1:0] offset      // Offset inside the region
);

    logic [7:0] bank8  [2**msx_pkg::cart_w][4];  // ascii8 banks per cartridge
    logic [7:0] bank16 [2**msx_pkg::cart_w][2];  // ascii16 banks per cartridge
    logic [1:0] win;                             // 8K window inside 4000-BFFF
    logic       hit8;
    logic       hit16;
    logic [7:0] sel8;
    logic [7:0] sel16;

    // Address relative to 4000, so pages 1-2 map banks 0-3
    assign win = req_addr[14:13] - 2'b10;

    // ascii8 registers in 6000-7FFF
    assign hit8 = (kind == msx_pkg::kind_ascii8) && (req_addr[15:13] == 3'b011);

    // ascii16 registers in 6000-67FF and 7000-77FF
    assign hit16 = (kind == msx_pkg::kind_ascii16) && (req_addr[15:13] == 3'b011)
                   && !req_addr[11];

    assign reg_hit = req_wr && (hit8 || hit16);

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < 2**msx_pkg::cart_w; c++) begin
                for (int b = 0; b < 4; b++) begin
                    bank8[c][b] <= 8'(b);          // Banks start at their index
                end
                bank16[c][0] <= 8'd0;
                bank16[c][1] <= 8'd1;
            end
        end else if (req_take && reg_hit) begin
            if (hit8) begin
                bank8[cart][req_addr[12:11]] <= req_wdata;  // Bits 12:11 pick bank
            end else begin
                bank16[cart][req_addr[12]] <= req_wdata;   // 6xxx bank 0, 7xxx bank 1
            end
        end
    end

    assign sel8  = bank8[cart][win];
    assign sel16 = bank16[cart][win[1]];

    // Bank times bank size plus in-bank address
    always_comb begin
        case (kind)
            msx_pkg::kind_ascii8: begin
                offset = msx_pkg::addr_w'({sel8, req_addr[msx_pkg::bank8_w-1:0]});
            end
            msx_pkg::kind_ascii16: begin
                offset = msx_pkg::addr_w'({sel16, req_addr[msx_pkg::page_w-1:0]});
            end
            msx_pkg::kind_linear: begin
                offset = msx_pkg::addr_w'(req_addr);  // Page x 16K plus 13:0
            end
            default: begin
                offset = '0;                          // Unmapped
            end
        endcase
    end

endmodule

/* logic/sdram_request.sv */
module sdram_request (
    input  logic                         clk_sdram,
    input  logic                         rst_n,
    // CPU side
    input  logic                         cpu_valid,
    input  logic [15:0]                  cpu_addr,
    input  logic                         cpu_wr,
    input  logic [7:0]                   cpu_wdata,
    output logic                         cpu_ready,
    output logic [7:0]                   cpu_rdata,
    // Captured request for the lookups
    output logic [15:0]                  req_addr,
    output logic                         req_wr,
    output logic [7:0]                   req_wdata,
    output logic                         req_take,
    // Lookup results
    input  logic                         exp_hit,
    input  logic [7:0]                   exp_rdata,
    input  logic [msx_pkg::kind_w-1:0]   kind,
    input  logic                         reg_hit,
    input  logic [msx_pkg::addr_w-1:0]   region_base,
    input  logic [msx_pkg::blocks_w-1:0] region_blocks,
    input  logic                         region_ro,
    input  logic [msx_pkg::addr_w-1:0]   offset,
    // Memory side
    output logic                         mem_valid,
    output logic [msx_pkg::addr_w-1:0]   mem_addr,
    output logic                         mem_wr,
    output logic [7:0]                   mem_wdata,
    input  logic                         mem_ready,
    input  logic [7:0]                   mem_rdata
);

    logic [1:0]                                    state;
    logic                                          fast;  // No memory cycle
    logic [msx_pkg::addr_w-msx_pkg::page_w-1:0]    blk;   // Wrapped 16K block

    assign req_take  = (state == msx_pkg::st_decide);  // One cycle per request
    assign cpu_ready = (state == msx_pkg::st_done);

    // Expander, unmapped, bank register and read-only writes end here
    assign fast = exp_hit || (kind == msx_pkg::kind_none) || reg_hit
                  || (req_wr && region_ro);

    // Offset wraps modulo the region size, block index only
    always_comb begin
        if (region_blocks == '0) begin
            blk = offset[msx_pkg::addr_w-1:msx_pkg::page_w];
        end else begin
            blk = offset[msx_pkg::addr_w-1:msx_pkg::page_w] % region_blocks;
        end
    end

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            state     <= msx_pkg::st_idle;
            mem_valid <= 1'b0;
        end else begin
            case (state)
                msx_pkg::st_idle: begin
                    if (cpu_valid) state <= msx_pkg::st_decide;
                end
                msx_pkg::st_decide: begin
                    if (fast) begin
                        state <= msx_pkg::st_done;
                    end else begin
                        state     <= msx_pkg::st_mem;
                        mem_valid <= 1'b1;        // Held until mem_ready
                    end
                end
                msx_pkg::st_mem: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        state     <= msx_pkg::st_done;
                    end
                end
                default: state <= msx_pkg::st_idle;  // cpu_valid drops now
            endcase
        end
    end

    // Request and memory payload
    always_ff @(posedge clk_sdram) begin
        if (state == msx_pkg::st_idle && cpu_valid) begin
            req_addr  <= cpu_addr;
            req_wr    <= cpu_wr;
            req_wdata <= cpu_wdata;
        end
        if (state == msx_pkg::st_decide) begin
            mem_addr  <= region_base + {blk, offset[msx_pkg::page_w-1:0]};
            mem_wr    <= req_wr;
            mem_wdata <= req_wdata;
            cpu_rdata <= exp_hit ? exp_rdata : msx_pkg::unmapped_data;
        end
        if (state == msx_pkg::st_mem && mem_ready) begin
            cpu_rdata <= mem_rdata;                // Transfer cycle data
        end
    end

endmodule

/* logic/msx_slots.sv */
module msx_slots (
    input  logic                         clk_sdram,
    input  logic                         rst_n,
    // CPU side
    input  logic                         cpu_valid,
    input  logic [15:0]                  cpu_addr,
    input  logic                         cpu_wr,
    input  logic [7:0]                   cpu_wdata,
    output logic                         cpu_ready,
    output logic [7:0]                   cpu_rdata,
    // Table configuration
    input  logic                         cfg_we,
    input  logic                         cfg_sel,
    input  logic [5:0]                   cfg_index,
    input  logic [msx_pkg::region_w-1:0] cfg_data,
    // SDRAM side
    output logic                         mem_valid,
    output logic [msx_pkg::addr_w-1:0]   mem_addr,
    output logic                         mem_wr,
    output logic [7:0]                   mem_wdata,
    input  logic                         mem_ready,
    input  logic [7:0]                   mem_rdata,
    // Slot selection
    input  logic [1:0]                   active_slot,
    input  logic [3:0]                   expander_en
);

    logic [15:0]                  req_addr;
    logic                         req_wr;
    logic [7:0]                   req_wdata;
    logic                         req_take;
    logic                         exp_hit;
    logic [1:0]                   subslot;
    logic [7:0]                   exp_rdata;
    logic [5:0]                   layout_id;
    logic [msx_pkg::kind_w-1:0]   kind;
    logic [msx_pkg::ref_w-1:0]    region_ref;
    logic [msx_pkg::addr_w-1:0]   region_base;
    logic [msx_pkg::blocks_w-1:0] region_blocks;
    logic                         region_ro;
    logic                         reg_hit;
    logic [msx_pkg::addr_w-1:0]   offset;

    assign layout_id = {active_slot, subslot, req_addr[15:14]};  // Slot, subslot, page

    slot_expander expander_i (
        .clk_sdram   (clk_sdram),
        .rst_n       (rst_n),
        .active_slot (active_slot),
        .expander_en (expander_en),
        .req_addr    (req_addr),
        .req_wr      (req_wr),
        .req_wdata   (req_wdata),
        .req_take    (req_take),
        .hit         (exp_hit),
        .subslot     (subslot),
        .rdata       (exp_rdata)
    );

    slot_layout_table table_i (
        .clk_sdram     (clk_sdram),
        .rst_n         (rst_n),
        .cfg_we        (cfg_we),
        .cfg_sel       (cfg_sel),
        .cfg_index     (cfg_index),
        .cfg_data      (cfg_data),
        .layout_id     (layout_id),
        .kind          (kind),
        .region_ref    (region_ref),
        .region_base   (region_base),
        .region_blocks (region_blocks),
        .region_ro     (region_ro)
    );

    // Cartridge bank set from bit 0 of the region reference
    mapper_bank mapper_i (
        .clk_sdram (clk_sdram),
        .rst_n     (rst_n),
        .kind      (kind),
        .cart      (region_ref[msx_pkg::cart_bit +: msx_pkg::cart_w]),
        .req_addr  (req_addr),
        .req_wr    (req_wr),
        .req_wdata (req_wdata),
        .req_take  (req_take),
        .reg_hit   (reg_hit),
        .offset    (offset)
    );

    sdram_request request_i (
        .clk_sdram     (clk_sdram),
        .rst_n         (rst_n),
        .cpu_valid     (cpu_valid),
        .cpu_addr      (cpu_addr),
        .cpu_wr        (cpu_wr),
        .cpu_wdata     (cpu_wdata),
        .cpu_ready     (cpu_ready),
        .cpu_rdata     (cpu_rdata),
        .req_addr      (req_addr),
        .req_wr        (req_wr),
        .req_wdata     (req_wdata),
        .req_take      (req_take),
        .exp_hit       (exp_hit),
        .exp_rdata     (exp_rdata),
        .kind          (kind),
        .reg_hit       (reg_hit),
        .region_base   (region_base),
        .region_blocks (region_blocks),
        .region_ro     (region_ro),
        .offset        (offset),
        .mem_valid     (mem_valid),
        .mem_addr      (mem_addr),
        .mem_wr        (mem_wr),
        .mem_wdata     (mem_wdata),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata)
    );

endmodule

/* sim/slots_checker.sv */
module slots_checker (
    input  logic        clk_sdram,
    input  logic        rst_n,
    input  logic        cpu_ready,
    input  logic [7:0]  cpu_rdata,
    input  logic        mem_valid,
    input  logic [26:0] mem_addr,
    input  logic        mem_wr,
    input  logic [7:0]  mem_wdata,
    input  logic        mem_ready,
    input  int          row_num,
    input  logic        exp_mem,      // Row expects one memory transfer
    input  logic [26:0] exp_maddr,
    input  logic        exp_wr,
    input  logic [7:0]  exp_wdata,
    input  logic [7:0]  exp_rdata,
    input  logic        check_rdata,
    output int          rows_ok,
    output int          rows_bad,
    output int          error_count
);

    int          row_errs;
    int          transfers;
    logic        held;        // mem_valid seen without mem_ready
    logic [26:0] held_addr;
    logic        held_wr;
    logic [7:0]  held_wdata;

    initial begin
        rows_ok     = 0;
        rows_bad    = 0;
        error_count = 0;
        row_errs    = 0;
        transfers   = 0;
        held        = 1'b0;
    end

    task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("[ERROR] row %0d %s got %0h expected %0h", row_num, name, got, want);
        row_errs++;
        error_count++;
    endtask

    task automatic text_error(input string what);
        $display("row %0d: %s", row_num, what);
        row_errs++;
        error_count++;
    endtask

    always @(posedge clk_sdram) begin
        if (rst_n) begin
            // Back-pressure, request must hold still
            if (held && !mem_valid) text_error("mem_valid dropped before mem_ready");
            if (held && mem_valid) begin
                if (mem_addr !== held_addr) value_error("mem_addr", mem_addr, held_addr);
                if (mem_wr !== held_wr) value_error("mem_wr", mem_wr, held_wr);
                if (mem_wdata !== held_wdata) value_error("mem_wdata", mem_wdata, held_wdata);
            end
            if (mem_valid && mem_ready) begin
                transfers++;
                if (!exp_mem) begin
                    text_error("memory transfer where none was expected");
                end else begin
                    if (mem_addr !== exp_maddr) value_error("mem_addr", mem_addr, exp_maddr);
                    if (mem_wr !== exp_wr) value_error("mem_wr", mem_wr, exp_wr);
                    if (exp_wr && mem_wdata !== exp_wdata) begin
                        value_error("mem_wdata", mem_wdata, exp_wdata);
                    end
                end
            end
            held       = mem_valid && !mem_ready;
            held_addr  = mem_addr;
            held_wr    = mem_wr;
            held_wdata = mem_wdata;
            // End of a row
            if (cpu_ready) begin
                if (exp_mem && transfers == 0) text_error("finished without a memory transfer");
                if (transfers > 1) text_error("more than one memory transfer");
                if (check_rdata && cpu_rdata !== exp_rdata) begin
                    value_error("cpu_rdata", cpu_rdata, exp_rdata);
                end
                if (row_errs == 0) begin
                    rows_ok++;
                    $display("row %0d ok", row_num);
                end else begin
                    rows_bad++;
                    $display("row %0d failed with %0d error(s)", row_num, row_errs);
                end
                row_errs  = 0;
                transfers = 0;
            end
        end
    end

endmodule

/* sim/tb_msx_slots.sv */
module tb_msx_slots;

    localparam int num_rows   = 23;
    localparam int wait_limit = 40;  // Cycles allowed per request

    logic        clk_sdram;
    logic        rst_n;
    logic        cpu_valid;
    logic [15:0] cpu_addr;
    logic        cpu_wr;
    logic [7:0]  cpu_wdata;
    logic        cpu_ready;
    logic [7:0]  cpu_rdata;
    logic        cfg_we;
    logic        cfg_sel;
    logic [5:0]  cfg_index;
    logic [35:0] cfg_data;
    logic        mem_valid;
    logic [26:0] mem_addr;
    logic        mem_wr;
    logic [7:0]  mem_wdata;
    logic        mem_ready;
    logic [7:0]  mem_rdata;
    logic [1:0]  active_slot;
    logic [3:0]  expander_en;

    // Row fields slot, enables, addr, wr, wdata, rdata, mem addr and mem cycle flag
    logic [66:0] rows [num_rows];
    logic [7:0]  store [logic [26:0]];  // Written SDRAM bytes
    integer      seed;
    int          delay;
    logic        busy;                  // Model counting down a request
    logic        timed_out;

    // Expectations of the current row for the checker
    int          row_num;
    logic        exp_mem;
    logic [26:0] exp_maddr;
    logic        exp_wr;
    logic [7:0]  exp_wdata;
    logic [7:0]  exp_rdata;
    logic        check_rdata;
    int          rows_ok;
    int          rows_bad;
    int          error_count;

    msx_slots dut_i (
        .clk_sdram (clk_sdram), .rst_n (rst_n),
        .cpu_valid (cpu_valid), .cpu_addr (cpu_addr), .cpu_wr (cpu_wr),
        .cpu_wdata (cpu_wdata), .cpu_ready (cpu_ready), .cpu_rdata (cpu_rdata),
        .cfg_we (cfg_we), .cfg_sel (cfg_sel), .cfg_index (cfg_index), .cfg_data (cfg_data),
        .mem_valid (mem_valid), .mem_addr (mem_addr), .mem_wr (mem_wr),
        .mem_wdata (mem_wdata), .mem_ready (mem_ready), .mem_rdata (mem_rdata),
        .active_slot (active_slot), .expander_en (expander_en)
    );

    slots_checker checker_i (
        .clk_sdram (clk_sdram), .rst_n (rst_n),
        .cpu_ready (cpu_ready), .cpu_rdata (cpu_rdata),
        .mem_valid (mem_valid), .mem_addr (mem_addr), .mem_wr (mem_wr),
        .mem_wdata (mem_wdata), .mem_ready (mem_ready),
        .row_num (row_num), .exp_mem (exp_mem), .exp_maddr (exp_maddr), .exp_wr (exp_wr),
        .exp_wdata (exp_wdata), .exp_rdata (exp_rdata), .check_rdata (check_rdata),
        .rows_ok (rows_ok), .rows_bad (rows_bad), .error_count (error_count)
    );

    initial begin
        clk_sdram = 1'b0;
        forever #10 clk_sdram = ~clk_sdram;
    end

    // SDRAM model raising mem_ready after 0 to 5 cycles
    always @(negedge clk_sdram) begin
        if (mem_ready) begin
            mem_ready <= 1'b0;  // Transfer took place on the last rising edge
            busy = 1'b0;
        end else if (mem_valid) begin
            if (!busy) begin
                busy  = 1'b1;
                delay = $unsigned($random(seed)) % 6;
            end
            if (delay == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= store.exists(mem_addr) ? store[mem_addr] : mem_addr[7:0] ^ 8'hA5;
            end else begin
                delay = delay - 1;
            end
        end
    end

    always @(posedge clk_sdram) begin
        if (mem_valid && mem_ready && mem_wr) store[mem_addr] = mem_wdata;
    end

    task automatic fill_rows();
        // Expander on slot 3 selects subslot 1 on every page and reads back inverted
        rows[0]  = {2'd3, 4'h8, 16'hFFFF, 1'b1, 8'h55, 8'h00, 27'h0, 1'b0};
        rows[1]  = {2'd3, 4'h8, 16'hFFFF, 1'b0, 8'h00, 8'hAA, 27'h0, 1'b0};
        // Linear RAM at 0100000
        rows[2]  = {2'd3, 4'h8, 16'hC000, 1'b1, 8'h3C, 8'h00, 27'h010C000, 1'b1};
        rows[3]  = {2'd3, 4'h8, 16'hC000, 1'b0, 8'h00, 8'h3C, 27'h010C000, 1'b1};
        rows[4]  = {2'd3, 4'h8, 16'h4123, 1'b1, 8'h77, 8'h00, 27'h0104123, 1'b1};
        rows[5]  = {2'd3, 4'h8, 16'h4123, 1'b0, 8'h00, 8'h77, 27'h0104123, 1'b1};
        rows[6]  = {2'd3, 4'h8, 16'h8055, 1'b0, 8'h00, 8'hF0, 27'h0108055, 1'b1};
        rows[7]  = {2'd2, 4'h8, 16'hFFFF, 1'b0, 8'h00, 8'h5A, 27'h010FFFF, 1'b1};  // Not expanded
        // Back to subslot 0 where page 3 is unmapped
        rows[8]  = {2'd3, 4'h8, 16'hFFFF, 1'b1, 8'h00, 8'h00, 27'h0, 1'b0};
        rows[9]  = {2'd3, 4'h8, 16'hC000, 1'b0, 8'h00, 8'hFF, 27'h0, 1'b0};
        rows[10] = {2'd3, 4'h8, 16'hFFFF, 1'b0, 8'h00, 8'hFF, 27'h0, 1'b0};
        // ascii8 cartridge in slot 1 with 4 blocks at 0200000
        rows[11] = {2'd1, 4'h8, 16'h6800, 1'b1, 8'h05, 8'h00, 27'h0, 1'b0};
        rows[12] = {2'd1, 4'h8, 16'h6010, 1'b0, 8'h00, 8'hB5, 27'h020A010, 1'b1};
        rows[13] = {2'd1, 4'h8, 16'h7FFF, 1'b0, 8'h00, 8'h5A, 27'h020BFFF, 1'b1};
        rows[14] = {2'd1, 4'h8, 16'h6800, 1'b1, 8'h0B, 8'h00, 27'h0, 1'b0};
        rows[15] = {2'd1, 4'h8, 16'h6004, 1'b0, 8'h00, 8'hA1, 27'h0206004, 1'b1};  // Wrapped
        rows[16] = {2'd1, 4'h8, 16'h4000, 1'b0, 8'h00, 8'hA5, 27'h0200000, 1'b1};
        rows[17] = {2'd1, 4'h8, 16'hA001, 1'b0, 8'h00, 8'hA4, 27'h0206001, 1'b1};
        // Read-only ROM in slot 0 drops the write
        rows[18] = {2'd0, 4'h8, 16'h0100, 1'b1, 8'h12, 8'h00, 27'h0, 1'b0};
        rows[19] = {2'd0, 4'h8, 16'h0100, 1'b0, 8'h00, 8'hA5, 27'h0300100, 1'b1};
        rows[20] = {2'd0, 4'h8, 16'h4201, 1'b0, 8'h00, 8'hA4, 27'h0304201, 1'b1};
        // Unmapped pages
        rows[21] = {2'd0, 4'h8, 16'h8000, 1'b0, 8'h00, 8'hFF, 27'h0, 1'b0};
        rows[22] = {2'd1, 4'h8, 16'hC000, 1'b1, 8'h99, 8'h00, 27'h0, 1'b0};
    endtask

    task automatic write_cfg(input logic sel, input logic [5:0] index, input logic [35:0] data);
        cfg_we    = 1'b1;
        cfg_sel   = sel;
        cfg_index = index;
        cfg_data  = data;
        @(negedge clk_sdram);
        cfg_we    = 1'b0;
    endtask

    // Region words are {ro, blocks, base} and layout words {kind, ref}
    task automatic load_tables();
        write_cfg(1'b1, 6'd0, 36'h0);
        write_cfg(1'b1, 6'd1, {1'b0, 8'd4, 27'h0100000});  // RAM
        write_cfg(1'b1, 6'd2, {1'b1, 8'd4, 27'h0200000});  // ascii8 ROM on cart 0
        write_cfg(1'b1, 6'd3, {1'b1, 8'd2, 27'h0300000});  // System ROM
        write_cfg(1'b0, 6'd0, 36'h13);
        write_cfg(1'b0, 6'd1, 36'h13);
        write_cfg(1'b0, 6'd17, 36'h22);                     // Slot 1 pages 1-2
        write_cfg(1'b0, 6'd18, 36'h22);
        write_cfg(1'b0, 6'd35, 36'h11);                     // Slot 2 page 3
        for (int p = 0; p < 4; p++) begin
            write_cfg(1'b0, 6'(52 + p), 36'h11);            // Slot 3 subslot 1
        end
    endtask

    task automatic run_row(input int i);
        logic [66:0] r;
        int          cycles;
        r = rows[i];
        active_slot = r[66:65];
        expander_en = r[64:61];
        row_num     = i;
        exp_mem     = r[0];
        exp_maddr   = r[27:1];
        exp_wr      = r[44];
        exp_wdata   = r[43:36];
        exp_rdata   = r[35:28];
        check_rdata = !r[44];  // Reads only
        cpu_addr    = r[60:45];
        cpu_wr      = r[44];
        cpu_wdata   = r[43:36];
        cpu_valid   = 1'b1;
        cycles      = 0;
        while (!cpu_ready && cycles < wait_limit) begin
            @(negedge clk_sdram);
            cycles++;
        end
        if (!cpu_ready) begin
            $display("row %0d: no cpu_ready within %0d cycles", i, wait_limit);
            timed_out = 1'b1;
        end
        cpu_valid = 1'b0;
        @(negedge clk_sdram);
    endtask

    initial begin
        seed        = 60838;
        busy        = 1'b0;
        delay       = 0;
        timed_out   = 1'b0;
        rst_n       = 1'b0;
        cpu_valid   = 1'b0;
        cpu_addr    = 16'h0;
        cpu_wr      = 1'b0;
        cpu_wdata   = 8'h00;
        cfg_we      = 1'b0;
        cfg_sel     = 1'b0;
        cfg_index   = 6'd0;
        cfg_data    = 36'h0;
        mem_ready   = 1'b0;
        mem_rdata   = 8'h00;
        active_slot = 2'd0;
        expander_en = 4'h0;
        row_num     = 0;
        exp_mem     = 1'b0;
        exp_maddr   = 27'h0;
        exp_wr      = 1'b0;
        exp_wdata   = 8'h00;
        exp_rdata   = 8'h00;
        check_rdata = 1'b0;
        fill_rows();
        repeat (2) @(posedge clk_sdram);  // Two clock cycles in reset
        @(negedge clk_sdram);
        rst_n = 1'b1;
        load_tables();
        for (int i = 0; i < num_rows && !timed_out; i++) begin
            run_row(i);
        end
        @(negedge clk_sdram);
        $display("rows passed %0d, rows failed %0d, errors %0d, timeouts %0d",
                 rows_ok, rows_bad, error_count, timed_out);
        if (timed_out || error_count != 0 || rows_ok != num_rows) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

/* build.f */
common/msx_pkg.sv
slots/slot_expander.sv
slots/slot_layout_table.sv
mappers/mapper_bank.sv
logic/sdram_request.sv
logic/msx_slots.sv
sim/slots_checker.sv
sim/tb_msx_slots.sv

/* Bender.yml */
package:
  name: msx_slots

sources:
  - files:
      - common/msx_pkg.sv
      - slots/slot_expander.sv
      - slots/slot_layout_table.sv
      - mappers/mapper_bank.sv
      - logic/sdram_request.sv
      - logic/msx_slots.sv
  - target: simulation
    files:
      - sim/slots_checker.sv
      - sim/tb_msx_slots.sv
